/* frame_writer.f */
source/frame_writer_pkg.sv
source/fifo_read_if.sv
source/pixel_packer.sv
source/word_fifo.sv
source/burst_writer.sv
source/frame_writer.sv
bench/frame_writer_props.sv
bench/frame_writer_tb.sv

/* bench/frame_writer_tb.sv */
`timescale 1ns/1ns

module frame_writer_tb;

	localparam int BURST_LEN = 16;
	localparam int WIDTH = 16;
	localparam int HEIGHT = 8;
	localparam int PIXELS = WIDTH * HEIGHT;
	localparam int FRAME_BURSTS = PIXELS / (4 * BURST_LEN);
	localparam int FRAMES = 5;
	localparam int TIMEOUT = 20000;

	logic clk = 1'b0;
	logic arst_n = 1'b1;
	logic s_axis_tvalid = 1'b0;
	frame_writer_pkg::pixel_t s_axis_tdata = '0;
	logic s_axis_tuser = 1'b0;
	logic s_axis_tlast = 1'b0;
	logic s_axis_tready;
	frame_writer_pkg::dim_t img_width = frame_writer_pkg::dim_t'(WIDTH);
	frame_writer_pkg::dim_t img_height = frame_writer_pkg::dim_t'(HEIGHT);
	frame_writer_pkg::addr_t base_addr = 32'h1080;
	frame_writer_pkg::addr_t awaddr;
	logic [7:0] awlen;
	logic [2:0] awsize;
	logic [1:0] awburst;
	logic awvalid;
	logic awready = 1'b0;
	frame_writer_pkg::bus_word_t wdata;
	logic [3:0] wstrb;
	logic wlast;
	logic wvalid;
	logic wready = 1'b0;
	logic [1:0] bresp = 2'b00;
	logic bvalid = 1'b0;
	logic bready;
	logic frame_pulse;
	logic frame_done;

	// Frame 1 sits just below frame 0 where an overrun would show
	frame_writer_pkg::addr_t bases [FRAMES] = '{32'h1080, 32'h1000, 32'h8000, 32'h8400, 32'h9000};
	frame_writer_pkg::pixel_t starts [FRAMES] = '{8'h00, 8'h5a, 8'h21, 8'hc3, 8'h7e};

	logic [7:0] mem [frame_writer_pkg::addr_t];
	frame_writer_pkg::addr_t wr_addr;
	int seed = 32'hd128;
	int errors = 0;
	int aw_seen = 0;
	int bursts = 0;
	int pulses = 0;
	int dones = 0;
	int stall_left = 0;
	logic b_pend = 1'b0;
	logic slow_mem = 1'b0;
	logic tready_dropped = 1'b0;

	frame_writer #(.BURST_LEN(BURST_LEN), .FIFO_DEPTH(64)) uut (.*);

	bind frame_writer frame_writer_props #(.BURST_LEN(BURST_LEN)) props (.*);

	always #10 clk = ~clk;

	////////////////////////////////////////////////////////////
	// AXI slave memory

	always @(posedge clk)
	begin
		if (awvalid && awready)
		begin
			wr_addr = awaddr;
			assert (frame_pulse === (aw_seen % FRAME_BURSTS == 0))
			else
			begin
				errors++;
				$display("Mismatch frame_pulse: burst %0d expected %0b actual %0b",
					aw_seen, aw_seen % FRAME_BURSTS == 0, frame_pulse);
			end
			aw_seen++;
		end
		if (frame_pulse)
			pulses++;
		if (wvalid && wready)
		begin
			for (int b = 0; b < 4; b++)
				mem[wr_addr + b] = wdata[8*b +: 8];
			wr_addr += 4;
			if (wlast)
				b_pend = 1'b1;
		end
		if (bvalid && bready)
		begin
			b_pend = 1'b0;
			bursts++;
			if (frame_done)
				dones++;
			// Done only on the response of a frame's last burst
			assert (frame_done === (bursts % FRAME_BURSTS == 0))
			else
			begin
				errors++;
				$display("Mismatch frame_done: response %0d expected %0b actual %0b",
					bursts, bursts % FRAME_BURSTS == 0, frame_done);
			end
		end
		if (slow_mem && s_axis_tvalid && !s_axis_tready)
			tready_dropped = 1'b1;

		#2;
		// Next frame's base is ready before its first burst opens
		if (dones < FRAMES)
			base_addr = bases[dones];
		awready = ($random(seed) & 3) != 0;
		if (stall_left > 0)
		begin
			stall_left--;
			wready = 1'b0;
		end
		else if (slow_mem && ($random(seed) & 63) == 0)
		begin
			stall_left = 60;
			wready = 1'b0;
		end
		else
			wready = ($random(seed) & 3) != 0;
		bvalid = b_pend && (bvalid || ($random(seed) & 1) != 0);
	end

	////////////////////////////////////////////////////////////
	// Stream driver and frame check

	task automatic send_frame(input frame_writer_pkg::pixel_t first);
		int k;
		int t;
		logic taken;
		k = 0;
		t = 0;
		while (k < PIXELS && t < TIMEOUT)
		begin
			@(posedge clk);
			taken = s_axis_tvalid && s_axis_tready;
			if (taken)
				k++;
			#2;
			// A pixel stays on the bus until it is taken
			if (taken || !s_axis_tvalid)
			begin
				s_axis_tvalid = k < PIXELS && ($random(seed) & 3) != 0;
				s_axis_tdata = 8'(first + k);
				s_axis_tuser = k == 0;
				s_axis_tlast = k % WIDTH == WIDTH - 1;
			end
			t++;
		end
		if (k < PIXELS)
		begin
			errors++;
			$display("Timeout: stream stalled after %0d of %0d pixels", k, PIXELS);
		end
	endtask

	task automatic check_frame(input int f);
		frame_writer_pkg::addr_t a;
		logic [7:0] expected;
		logic [7:0] actual;
		for (int k = 0; k < PIXELS; k++)
		begin
			a = bases[f] + k;
			expected = 8'(starts[f] + k);
			actual = mem.exists(a) ? mem[a] : 8'hxx;
			assert (actual === expected)
			else
			begin
				errors++;
				$display("Mismatch frame%0d_data: byte %0d expected %h actual %h",
					f, k, expected, actual);
			end
		end
	endtask

	initial
	begin : main
		int t;
		#1;
		arst_n = 1'b0;
		repeat (16) @(posedge clk);
		#2;
		arst_n = 1'b1;

		// Frames 2 to 4 run behind long wready stalls
		for (int f = 0; f < FRAMES; f++)
		begin
			if (f == 2)
			begin
				slow_mem = 1'b1;
				stall_left = 600;
			end
			send_frame(starts[f]);
		end

		t = 0;
		while (dones < FRAMES && t < TIMEOUT)
		begin
			@(posedge clk);
			t++;
		end
		if (dones < FRAMES)
		begin
			errors++;
			$display("Timeout: only %0d of %0d frames finished", dones, FRAMES);
		end

		for (int f = 0; f < FRAMES; f++)
			check_frame(f);
		assert (pulses == FRAMES)
		else
		begin
			errors++;
			$display("Mismatch frame_pulse_count: expected %0d actual %0d", FRAMES, pulses);
		end
		assert (tready_dropped)
		else
		begin
			errors++;
			$display("Stream tready never dropped during memory stalls");
		end

		$display("Errors: %0d check, %0d property", errors, uut.props.fail_count);
		if (errors == 0 && uut.props.fail_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* bench/frame_writer_props.sv */
`timescale 1ns/1ns

module frame_writer_props #(
	parameter int BURST_LEN = 16
)
(
	input logic                        clk,
	input logic                        arst_n,
	input logic                        s_axis_tready,
	input logic                        wr_en,
	input logic                        full,
	input frame_writer_pkg::addr_t     awaddr,
	input logic [7:0]                  awlen,
	input logic [2:0]                  awsize,
	input logic [1:0]                  awburst,
	input logic                        awvalid,
	input logic                        awready,
	input frame_writer_pkg::bus_word_t wdata,
	input logic [3:0]                  wstrb,
	input logic                        wlast,
	input logic                        wvalid,
	input logic                        wready,
	input logic                        bready,
	input logic                        frame_pulse,
	input logic                        frame_done
);

	int fail_count = 0;
	int beat;

	// Accepted beats within the current burst
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			beat <= 0;
		else if (wvalid && wready)
			beat <= (beat == BURST_LEN - 1) ? 0 : beat + 1;
	end

	////////////////////////////////////////////////////////////
	// Reset and burst format

	reset_quiet: assert property (@(posedge clk) !arst_n |-> !(s_axis_tready || wr_en
		|| awvalid || wvalid || wlast || bready || frame_pulse || frame_done))
	else
	begin
		fail_count++;
		$error("Control output high during reset");
	end

	aw_format: assert property (@(posedge clk) disable iff (!arst_n)
		awvalid |-> awlen == 8'(BURST_LEN - 1) && awsize == 3'd2 && awburst == 2'b01)
	else
	begin
		fail_count++;
		$error("Write address carries wrong burst length, size or type");
	end

	// wlast belongs on every BURST_LEN-th beat and nowhere else
	w_format: assert property (@(posedge clk) disable iff (!arst_n)
		wvalid |-> wstrb == 4'hf && wlast == (beat == BURST_LEN - 1))
	else
	begin
		fail_count++;
		$error("Write data beat has wrong strobe or misplaced wlast");
	end

	////////////////////////////////////////////////////////////
	// Handshake stability and FIFO overflow

	aw_hold: assert property (@(posedge clk) disable iff (!arst_n)
		awvalid && !awready |=> awvalid && $stable(awaddr))
	else
	begin
		fail_count++;
		$error("awvalid or awaddr changed before awready");
	end

	w_hold: assert property (@(posedge clk) disable iff (!arst_n)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
	else
	begin
		fail_count++;
		$error("wvalid, wdata or wlast changed before wready");
	end

	no_overflow: assert property (@(posedge clk) disable iff (!arst_n) !(wr_en && full))
	else
	begin
		fail_count++;
		$error("Packer wrote into a full FIFO");
	end

endmodule

/* source/frame_writer.sv */
`timescale 1ns/1ns

module frame_writer #(
	parameter int BURST_LEN  = 16,
	parameter int FIFO_DEPTH = 64
)
(
	input  logic                        clk,
	input  logic                        arst_n,

	// Pixel stream
	input  logic                        s_axis_tvalid,
	input  frame_writer_pkg::pixel_t    s_axis_tdata,
	input  logic                        s_axis_tuser,
	input  logic                        s_axis_tlast,
	output logic                        s_axis_tready,

	// Frame geometry and placement
	input  frame_writer_pkg::dim_t      img_width,
	input  frame_writer_pkg::dim_t      img_height,
	input  frame_writer_pkg::addr_t     base_addr,

	// AXI4 write master
	output frame_writer_pkg::addr_t     awaddr,
	output logic [7:0]                  awlen,
	output logic [2:0]                  awsize,
	output logic [1:0]                  awburst,
	output logic                        awvalid,
	input  logic                        awready,
	output frame_writer_pkg::bus_word_t wdata,
	output logic [3:0]                  wstrb,
	output logic                        wlast,
	output logic                        wvalid,
	input  logic                        wready,
	input  logic [1:0]                  bresp,
	input  logic                        bvalid,
	output logic                        bready,

	output logic                        frame_pulse,
	output logic                        frame_done
);

	// Count runs from 0 to FIFO_DEPTH inclusive
	localparam int COUNT_W = $clog2(FIFO_DEPTH) + 1;

	logic wr_en;
	frame_writer_pkg::fifo_word_t wr_data;
	logic full;

	fifo_read_if #(.COUNT_W(COUNT_W)) rd_if ();

	////////////////////////////////////////////////////////////
	// Stream side

	pixel_packer packer (
		.clk           (clk),
		.arst_n        (arst_n),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tdata  (s_axis_tdata),
		.s_axis_tuser  (s_axis_tuser),
		.s_axis_tlast  (s_axis_tlast),
		.s_axis_tready (s_axis_tready),
		.wr_en         (wr_en),
		.wr_data       (wr_data),
		.full          (full)
	);

	word_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH),
		.COUNT_W    (COUNT_W)
	) fifo (
		.clk     (clk),
		.arst_n  (arst_n),
		.wr_en   (wr_en),
		.wr_data (wr_data),
		.full    (full),
		.rd      (rd_if.buffer)
	);

	////////////////////////////////////////////////////////////
	// Memory side

	burst_writer #(
		.BURST_LEN (BURST_LEN),
		.COUNT_W   (COUNT_W)
	) writer (
		.clk         (clk),
		.arst_n      (arst_n),
		.rd          (rd_if.reader),
		.img_width   (img_width),
		.img_height  (img_height),
		.base_addr   (base_addr),
		.awaddr      (awaddr),
		.awlen       (awlen),
		.awsize      (awsize),
		.awburst     (awburst),
		.awvalid     (awvalid),
		.awready     (awready),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.wlast       (wlast),
		.wvalid      (wvalid),
		.wready      (wready),
		.bresp       (bresp),
		.bvalid      (bvalid),
		.bready      (bready),
		.frame_pulse (frame_pulse),
		.frame_done  (frame_done)
	);

endmodule

/* source/burst_writer.sv */
`timescale 1ns/1ns

module burst_writer #(
	parameter int BURST_LEN = 16,
	parameter int COUNT_W   = 7
)
(
	input  logic                        clk,
	input  logic                        arst_n,

	fifo_read_if.reader                 rd,

	input  frame_writer_pkg::dim_t      img_width,
	input  frame_writer_pkg::dim_t      img_height,
	input  frame_writer_pkg::addr_t     base_addr,

	output frame_writer_pkg::addr_t     awaddr,
	output logic [7:0]                  awlen,
	output logic [2:0]                  awsize,
	output logic [1:0]                  awburst,
	output logic                        awvalid,
	input  logic                        awready,

	output frame_writer_pkg::bus_word_t wdata,
	output logic [3:0]                  wstrb,
	output logic                        wlast,
	output logic                        wvalid,
	input  logic                        wready,

	input  logic [1:0]                  bresp,
	input  logic                        bvalid,
	output logic                        bready,

	output logic                        frame_pulse,
	output logic                        frame_done
);

	localparam int BYTES = frame_writer_pkg::BUS_W / 8;
	localparam int BURST_BYTES = BURST_LEN * BYTES;
	localparam int BEAT_W = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;
	localparam int FRAME_W = 2 * frame_writer_pkg::DIM_W;

	frame_writer_pkg::burst_state_e state;
	logic [BEAT_W-1:0] beat;
	logic [FRAME_W-1:0] frame_pixels;
	logic [FRAME_W-1:0] frame_bursts;
	logic [FRAME_W-1:0] left;
	logic first_q;
	logic last_q;
	logic burst_ready;
	logic head_sof;
	logic resp_taken;
	frame_writer_pkg::addr_t start_addr;
	frame_writer_pkg::addr_t next_addr;
	frame_writer_pkg::addr_t awaddr_q;

	////////////////////////////////////////////////////////////
	// Burst constants and channel outputs

	assign awlen = 8'(BURST_LEN - 1);
	assign awsize = 3'($clog2(BYTES));
	// INCR
	assign awburst = 2'b01;
	assign wstrb = '1;

	assign awaddr = awaddr_q;
	assign awvalid = state == frame_writer_pkg::ADDR;

	assign wdata = rd.head[frame_writer_pkg::BUS_W-1:0];
	assign wvalid = state == frame_writer_pkg::DATA && !rd.empty;
	assign wlast = state == frame_writer_pkg::DATA && beat == BEAT_W'(BURST_LEN - 1);
	assign rd.rd_en = wvalid && wready;

	assign bready = state == frame_writer_pkg::RESP;

	// Response code takes no part in frame tracking
	assign resp_taken = bvalid && bready;

	assign frame_pulse = awvalid && awready && first_q;
	assign frame_done = resp_taken && last_q;

	////////////////////////////////////////////////////////////
	// Frame bookkeeping

	// With a whole burst waiting the head is that burst's first word
	assign burst_ready = rd.count >= COUNT_W'(BURST_LEN);
	assign head_sof = rd.head[frame_writer_pkg::SOF_BIT];
	assign start_addr = head_sof ? base_addr : next_addr;

	assign frame_pixels = FRAME_W'(img_width) * FRAME_W'(img_height);
	assign frame_bursts = frame_pixels / FRAME_W'(frame_writer_pkg::WORD_PIXELS * BURST_LEN);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= frame_writer_pkg::IDLE;
			beat <= '0;
			left <= '0;
			first_q <= 1'b0;
			last_q <= 1'b0;
		end
		else
		begin
			case (state)
				frame_writer_pkg::IDLE:
				begin
					if (burst_ready)
					begin
						state <= frame_writer_pkg::ADDR;
						first_q <= head_sof;
						if (head_sof)
						begin
							// New frame reloads the burst budget
							left <= frame_bursts - FRAME_W'(1);
							last_q <= frame_bursts == FRAME_W'(1);
						end
						else
						begin
							last_q <= left == FRAME_W'(1);
							if (left != '0)
								left <= left - FRAME_W'(1);
						end
					end
				end

				frame_writer_pkg::ADDR:
				begin
					if (awready)
						state <= frame_writer_pkg::DATA;
				end

				frame_writer_pkg::DATA:
				begin
					if (rd.rd_en)
					begin
						if (wlast)
						begin
							state <= frame_writer_pkg::RESP;
							beat <= '0;
						end
						else
						begin
							beat <= beat + BEAT_W'(1);
						end
					end
				end

				frame_writer_pkg::RESP:
				begin
					if (bvalid)
						state <= frame_writer_pkg::IDLE;
				end

				default:
				begin
					state <= frame_writer_pkg::IDLE;
				end
			endcase
		end
	end

	// Address of the burst being opened and of the one after it
	always_ff @(posedge clk)
	begin
		if (state == frame_writer_pkg::IDLE && burst_ready)
		begin
			awaddr_q <= start_addr;
			next_addr <= start_addr + frame_writer_pkg::addr_t'(BURST_BYTES);
		end
	end

endmodule

/* source/word_fifo.sv */
`timescale 1ns/1ns

module word_fifo #(
	parameter int FIFO_DEPTH = 64,
	parameter int COUNT_W    = 7
)
(
	input  logic                         clk,
	input  logic                         arst_n,

	input  logic                         wr_en,
	input  frame_writer_pkg::fifo_word_t wr_data,
	output logic                         full,

	fifo_read_if.buffer                  rd
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	frame_writer_pkg::fifo_word_t mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [COUNT_W-1:0] count;
	logic do_wr;
	logic do_rd;

	assign full = count == COUNT_W'(FIFO_DEPTH);
	assign do_wr = wr_en && !full;
	assign do_rd = rd.rd_en && !rd.empty;

	// Show-ahead read port
	assign rd.head = mem[rd_ptr];
	assign rd.empty = count == '0;
	assign rd.count = count;

	////////////////////////////////////////////////////////////
	// Pointers and fill count

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + PTR_W'(1);
			if (do_rd)
				rd_ptr <= rd_ptr + PTR_W'(1);

			// Push and pop in one cycle leave the count alone
			if (do_wr && !do_rd)
				count <= count + COUNT_W'(1);
			else if (do_rd && !do_wr)
				count <= count - COUNT_W'(1);
		end
	end

	////////////////////////////////////////////////////////////
	// Storage

	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

endmodule

/* source/pixel_packer.sv */
`timescale 1ns/1ns

module pixel_packer
(
	input  logic                         clk,
	input  logic                         arst_n,

	input  logic                         s_axis_tvalid,
	input  frame_writer_pkg::pixel_t     s_axis_tdata,
	input  logic                         s_axis_tuser,
	input  logic                         s_axis_tlast,
	output logic                         s_axis_tready,

	output logic                         wr_en,
	output frame_writer_pkg::fifo_word_t wr_data,
	input  logic                         full
);

	localparam int LANE_W = $clog2(frame_writer_pkg::WORD_PIXELS);
	localparam int BUS_W = frame_writer_pkg::BUS_W;
	localparam int PIXEL_W = frame_writer_pkg::PIXEL_W;

	frame_writer_pkg::pack_state_e state;
	logic [LANE_W-1:0] lane;
	logic run;
	logic accept;
	logic word_end;
	frame_writer_pkg::bus_word_t shift;
	logic sof_q;
	frame_writer_pkg::fifo_word_t word_q;

	// In HOLD a new pixel is taken only on the cycle the held word leaves
	assign s_axis_tready = run && (state == frame_writer_pkg::FILL || !full);
	assign accept = s_axis_tvalid && s_axis_tready;

	// A tuser pixel opens a new word and never closes one
	assign word_end = accept && !s_axis_tuser
		&& lane == LANE_W'(frame_writer_pkg::WORD_PIXELS - 1);

	assign wr_en = state == frame_writer_pkg::HOLD && !full;
	assign wr_data = word_q;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= frame_writer_pkg::FILL;
			lane <= '0;
			run <= 1'b0;
		end
		else
		begin
			run <= 1'b1;
			if (word_end)
				state <= frame_writer_pkg::HOLD;
			else if (state == frame_writer_pkg::HOLD && !full)
				state <= frame_writer_pkg::FILL;

			if (accept)
			begin
				if (s_axis_tuser)
					lane <= LANE_W'(1);
				else if (word_end)
					lane <= '0;
				else
					lane <= lane + LANE_W'(1);
			end
		end
	end

	// Pixels enter at the top and move down to byte 0
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			shift <= {s_axis_tdata, shift[BUS_W-1:PIXEL_W]};
			if (s_axis_tuser || lane == '0)
				sof_q <= s_axis_tuser;
			if (word_end)
			begin
				word_q[BUS_W-1:0] <= {s_axis_tdata, shift[BUS_W-1:PIXEL_W]};
				word_q[frame_writer_pkg::SOF_BIT] <= sof_q;
				word_q[frame_writer_pkg::EOL_BIT] <= s_axis_tlast;
			end
		end
	end

endmodule

/* source/fifo_read_if.sv */
`timescale 1ns/1ns

interface fifo_read_if #(
	parameter int COUNT_W = 7
) ();

	// Oldest entry is valid while empty is low
	frame_writer_pkg::fifo_word_t head;
	logic empty;
	logic [COUNT_W-1:0] count;

	// Pops head at the next edge
	logic rd_en;

	modport buffer (
		output head,
		output empty,
		output count,
		input  rd_en
	);

	modport reader (
		input  head,
		input  empty,
		input  count,
		output rd_en
	);

endinterface

/* source/frame_writer_pkg.sv */
package frame_writer_pkg;

	////////////////////////////////////////////////////////////
	// Widths

	localparam int PIXEL_W = 8;
	localparam int WORD_PIXELS = 4;
	localparam int BUS_W = PIXEL_W * WORD_PIXELS;
	localparam int ADDR_W = 32;
	localparam int DIM_W = 12;

	// Flag positions above the data word in a FIFO entry
	localparam int SOF_BIT = BUS_W;
	localparam int EOL_BIT = BUS_W + 1;

	////////////////////////////////////////////////////////////
	// Types

	typedef logic [PIXEL_W-1:0] pixel_t;
	typedef logic [BUS_W-1:0] bus_word_t;
	typedef logic [BUS_W+1:0] fifo_word_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DIM_W-1:0] dim_t;

	typedef enum logic {FILL, HOLD} pack_state_e;

	typedef enum logic [1:0] {IDLE, ADDR, DATA, RESP} burst_state_e;

endpackage
